// ==== hdl/csr_pkg.sv ====
// csr package: operation codes, csr addresses, event indices and status bit fields
`default_nettype none

package csr_pkg;

  // port widths
  localparam int XLEN       = 32;
  localparam int CSR_ADDR_W = 12;

  // csr operations from the decoder
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  //////////////////////////////
  // machine csr addresses
  //////////////////////////////
  localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS   = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC     = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC      = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE    = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID   = 12'hF14;

  // perf counter block, counters at base + index
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCER      = 12'h7A0;
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCMR      = 12'h7A1;
  localparam logic [CSR_ADDR_W-1:0] ADDR_PCCR_BASE = 12'h780;

  //////////////////////////////
  // performance events
  //////////////////////////////
  localparam int N_PERF_EVT       = 11;

  localparam int EVT_CYCLE        = 0;
  localparam int EVT_INSTR        = 1;
  localparam int EVT_LD_STALL     = 2;
  localparam int EVT_JR_STALL     = 3;
  localparam int EVT_IMISS        = 4;
  localparam int EVT_LOAD         = 5;
  localparam int EVT_STORE        = 6;
  localparam int EVT_JUMP         = 7;
  localparam int EVT_BRANCH       = 8;
  localparam int EVT_BRANCH_TAKEN = 9;
  localparam int EVT_COMPRESSED   = 10;

  // mstatus fields, mpp is two bits fixed at machine
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LO   = 11;

  // stored cause, top bit flags an interrupt
  localparam int MCAUSE_W = 6;

  // mode register: bit 0 global enable, bit 1 saturate
  localparam int PCMR_W   = 2;

endpackage

`default_nettype wire

// ==== hdl/perf_counter_bank.sv ====
// performance counter array with saturating increment, csr writes and indexed read
`timescale 1ns/1ps
`default_nettype none

module perf_counter_bank #(
  parameter int CNT_W = 32
) (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic [csr_pkg::N_PERF_EVT-1:0] cnt_inc_i,
  input  wire logic                           sat_en_i,
  input  wire logic [csr_pkg::N_PERF_EVT-1:0] pccr_we_i,
  input  wire logic [3:0]                     pccr_idx_i,
  input  wire logic [csr_pkg::XLEN-1:0]       csr_wdata_i,
  output logic      [csr_pkg::XLEN-1:0]       pccr_rd_o
);

  import csr_pkg::*;

  logic [CNT_W-1:0] cnt_q [N_PERF_EVT];

  //////////////////////////////
  // counter update
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < N_PERF_EVT; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < N_PERF_EVT; i++) begin
        if (pccr_we_i[i]) begin
          // software write beats the increment
          cnt_q[i] <= csr_wdata_i[CNT_W-1:0];
        end else if (cnt_inc_i[i] && !(sat_en_i && (&cnt_q[i]))) begin
          // wraps when saturation is off
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // indexed read, zero-extended to the port width
  always_comb begin
    pccr_rd_o = '0;
    if (pccr_idx_i < N_PERF_EVT) begin
      pccr_rd_o[CNT_W-1:0] = cnt_q[pccr_idx_i];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/perf_event_gen.sv ====
// perf event conditioning with the pcer and pcmr registers and registered increments
`timescale 1ns/1ps
`default_nettype none

module perf_event_gen (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                           id_valid_i,
  input  wire logic                           is_compressed_i,
  input  wire logic                           is_decoding_i,
  input  wire logic                           imiss_i,
  input  wire logic                           pc_set_i,
  input  wire logic                           jump_i,
  input  wire logic                           branch_i,
  input  wire logic                           branch_taken_i,
  input  wire logic                           ld_stall_i,
  input  wire logic                           jr_stall_i,
  input  wire logic                           mem_load_i,
  input  wire logic                           mem_store_i,
  input  wire logic [csr_pkg::XLEN-1:0]       csr_wdata_i,
  input  wire logic                           pcer_we_i,
  input  wire logic                           pcmr_we_i,
  output logic      [csr_pkg::N_PERF_EVT-1:0] pcer_rd_o,
  output logic      [csr_pkg::PCMR_W-1:0]     pcmr_rd_o,
  output logic      [csr_pkg::N_PERF_EVT-1:0] cnt_inc_o,
  output logic                                sat_en_o
);

  import csr_pkg::*;

  logic                  id_valid_q;
  logic [N_PERF_EVT-1:0] evt;
  logic [N_PERF_EVT-1:0] pcer_q;
  logic [PCMR_W-1:0]     pcmr_q;

  //////////////////////////////
  // event conditions
  //////////////////////////////
  assign evt[EVT_CYCLE]        = 1'b1;
  assign evt[EVT_INSTR]        = id_valid_i & is_decoding_i;
  // stalls and control flow qualified by last cycle's id_valid
  assign evt[EVT_LD_STALL]     = ld_stall_i & id_valid_q;
  assign evt[EVT_JR_STALL]     = jr_stall_i & id_valid_q;
  // fetch wait, not counting redirects
  assign evt[EVT_IMISS]        = imiss_i & ~pc_set_i;
  assign evt[EVT_LOAD]         = mem_load_i;
  assign evt[EVT_STORE]        = mem_store_i;
  assign evt[EVT_JUMP]         = jump_i & id_valid_q;
  assign evt[EVT_BRANCH]       = branch_i & id_valid_q;
  assign evt[EVT_BRANCH_TAKEN] = branch_i & branch_taken_i & id_valid_q;
  assign evt[EVT_COMPRESSED]   = id_valid_i & is_decoding_i & is_compressed_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      pcer_q     <= '0;
      // enabled and saturating out of reset
      pcmr_q     <= 2'b11;
      cnt_inc_o  <= '0;
    end else begin
      id_valid_q <= id_valid_i;
      if (pcer_we_i) begin
        pcer_q <= csr_wdata_i[N_PERF_EVT-1:0];
      end
      if (pcmr_we_i) begin
        pcmr_q <= csr_wdata_i[PCMR_W-1:0];
      end
      // per-event enable and global enable, one cycle ahead of the counter
      cnt_inc_o  <= evt & pcer_q & {N_PERF_EVT{pcmr_q[0]}};
    end
  end

  assign pcer_rd_o = pcer_q;
  assign pcmr_rd_o = pcmr_q;
  assign sat_en_o  = pcmr_q[1];

endmodule

`default_nettype wire

// ==== hdl/csr_trap_regs.sv ====
// machine trap registers: mstatus, mepc and mcause with trap save and mret restore
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs (
  input  wire logic                         clk,
  input  wire logic                         rst_n,
  input  wire logic [csr_pkg::XLEN-1:0]     csr_wdata_i,
  input  wire logic                         mstatus_we_i,
  input  wire logic                         mepc_we_i,
  input  wire logic                         mcause_we_i,
  input  wire logic                         csr_save_cause_i,
  input  wire logic                         csr_save_if_i,
  input  wire logic                         csr_save_id_i,
  input  wire logic                         csr_restore_mret_i,
  input  wire logic [csr_pkg::XLEN-1:0]     pc_if_i,
  input  wire logic [csr_pkg::XLEN-1:0]     pc_id_i,
  input  wire logic [csr_pkg::MCAUSE_W-1:0] csr_cause_i,
  output logic      [1:0]                   mstatus_rd_o,
  output logic      [csr_pkg::XLEN-1:0]     mepc_rd_o,
  output logic      [csr_pkg::MCAUSE_W-1:0] mcause_rd_o,
  output logic      [csr_pkg::XLEN-1:0]     epc_o,
  output logic                              m_irq_enable_o
);

  import csr_pkg::*;

  logic                mie_q;
  logic                mie_n;
  logic                mpie_q;
  logic                mpie_n;
  logic [XLEN-1:0]     mepc_q;
  logic [XLEN-1:0]     mepc_n;
  logic [MCAUSE_W-1:0] mcause_q;
  logic [MCAUSE_W-1:0] mcause_n;
  logic [XLEN-1:0]     exception_pc;

  // if stage pc wins, id stage pc otherwise
  assign exception_pc = csr_save_if_i ? pc_if_i : pc_id_i;

  //////////////////////////////
  // next state
  //////////////////////////////
  always_comb begin
    mie_n    = mie_q;
    mpie_n   = mpie_q;
    mepc_n   = mepc_q;
    mcause_n = mcause_q;
    if (csr_save_cause_i) begin
      // trap entry, stack the enable
      mepc_n   = exception_pc;
      mcause_n = csr_cause_i;
      mpie_n   = mie_q;
      mie_n    = 1'b0;
    end else if (csr_restore_mret_i) begin
      // pop the enable stack
      mie_n  = mpie_q;
      mpie_n = 1'b1;
    end else begin
      // plain csr writes, only mie and mpie writable
      if (mstatus_we_i) begin
        mie_n  = csr_wdata_i[MSTATUS_MIE_BIT];
        mpie_n = csr_wdata_i[MSTATUS_MPIE_BIT];
      end
      if (mepc_we_i) begin
        mepc_n = csr_wdata_i;
      end
      if (mcause_we_i) begin
        mcause_n = csr_wdata_i[MCAUSE_W-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      mie_q    <= mie_n;
      mpie_q   <= mpie_n;
      mepc_q   <= mepc_n;
      mcause_q <= mcause_n;
    end
  end

  // raw fields back to the decoder
  assign mstatus_rd_o   = {mpie_q, mie_q};
  assign mepc_rd_o      = mepc_q;
  assign mcause_rd_o    = mcause_q;

  // controller side
  assign epc_o          = mepc_q;
  assign m_irq_enable_o = mie_q;

endmodule

`default_nettype wire

// ==== hdl/csr_access_ctrl.sv ====
// csr access decoder: address decode, read mux and read-modify-write data
`timescale 1ns/1ps
`default_nettype none

module csr_access_ctrl (
  input  wire logic                             csr_access_i,
  input  wire logic [csr_pkg::CSR_ADDR_W-1:0]   csr_addr_i,
  input  csr_pkg::csr_op_e                      csr_op_i,
  input  wire logic [csr_pkg::XLEN-1:0]         csr_wdata_i,
  input  wire logic [3:0]                       core_id_i,
  input  wire logic [5:0]                       cluster_id_i,
  input  wire logic [23:0]                      boot_addr_i,
  input  wire logic [1:0]                       mstatus_rd_i,
  input  wire logic [csr_pkg::XLEN-1:0]         mepc_rd_i,
  input  wire logic [csr_pkg::MCAUSE_W-1:0]     mcause_rd_i,
  input  wire logic [csr_pkg::N_PERF_EVT-1:0]   pcer_rd_i,
  input  wire logic [csr_pkg::PCMR_W-1:0]       pcmr_rd_i,
  input  wire logic [csr_pkg::XLEN-1:0]         pccr_rd_i,
  output logic      [csr_pkg::XLEN-1:0]         csr_rdata_o,
  output logic      [csr_pkg::XLEN-1:0]         csr_wdata_int_o,
  output logic                                  mstatus_we_o,
  output logic                                  mepc_we_o,
  output logic                                  mcause_we_o,
  output logic                                  pcer_we_o,
  output logic                                  pcmr_we_o,
  output logic      [csr_pkg::N_PERF_EVT-1:0]   pccr_we_o,
  output logic      [3:0]                       pccr_idx_o
);

  import csr_pkg::*;

  logic is_mstatus;
  logic is_mepc;
  logic is_mcause;
  logic is_pcer;
  logic is_pcmr;
  logic is_pccr;
  logic csr_we;

  // counters live at 0x780 + idx, only the first N_PERF_EVT exist
  assign pccr_idx_o = csr_addr_i[3:0];
  assign is_pccr    = (csr_addr_i[11:4] == ADDR_PCCR_BASE[11:4]) &&
                      (pccr_idx_o < N_PERF_EVT);

  //////////////////////////////
  // decode and read mux
  //////////////////////////////
  always_comb begin
    is_mstatus  = 1'b0;
    is_mepc     = 1'b0;
    is_mcause   = 1'b0;
    is_pcer     = 1'b0;
    is_pcmr     = 1'b0;
    // unknown addresses fall through as zero
    csr_rdata_o = '0;
    case (csr_addr_i)
      ADDR_MSTATUS: begin
        is_mstatus = 1'b1;
        // mpp hardwired to machine
        csr_rdata_o[MSTATUS_MPP_LO+1:MSTATUS_MPP_LO] = 2'b11;
        csr_rdata_o[MSTATUS_MPIE_BIT] = mstatus_rd_i[1];
        csr_rdata_o[MSTATUS_MIE_BIT]  = mstatus_rd_i[0];
      end
      ADDR_MTVEC: begin
        csr_rdata_o = {boot_addr_i, 8'h00};
      end
      ADDR_MEPC: begin
        is_mepc     = 1'b1;
        csr_rdata_o = mepc_rd_i;
      end
      ADDR_MCAUSE: begin
        is_mcause = 1'b1;
        // interrupt flag moves up to the msb
        csr_rdata_o[XLEN-1]         = mcause_rd_i[MCAUSE_W-1];
        csr_rdata_o[MCAUSE_W-2:0]   = mcause_rd_i[MCAUSE_W-2:0];
      end
      ADDR_MHARTID: begin
        csr_rdata_o = {21'b0, cluster_id_i, 1'b0, core_id_i};
      end
      ADDR_PCER: begin
        is_pcer = 1'b1;
        csr_rdata_o[N_PERF_EVT-1:0] = pcer_rd_i;
      end
      ADDR_PCMR: begin
        is_pcmr = 1'b1;
        csr_rdata_o[PCMR_W-1:0] = pcmr_rd_i;
      end
      default: begin
        if (is_pccr) begin
          csr_rdata_o = pccr_rd_i;
        end
      end
    endcase
  end

  //////////////////////////////
  // write data and strobes
  //////////////////////////////
  always_comb begin
    case (csr_op_i)
      CSR_OP_SET:   csr_wdata_int_o = csr_wdata_i | csr_rdata_o;
      CSR_OP_CLEAR: csr_wdata_int_o = csr_rdata_o & ~csr_wdata_i;
      // write and none pass the data through
      default:      csr_wdata_int_o = csr_wdata_i;
    endcase
  end

  assign csr_we = csr_access_i && (csr_op_i != CSR_OP_NONE);

  assign mstatus_we_o = csr_we && is_mstatus;
  assign mepc_we_o    = csr_we && is_mepc;
  assign mcause_we_o  = csr_we && is_mcause;
  assign pcer_we_o    = csr_we && is_pcer;
  assign pcmr_we_o    = csr_we && is_pcmr;

  // one-hot counter strobe
  always_comb begin
    for (int i = 0; i < N_PERF_EVT; i++) begin
      pccr_we_o[i] = csr_we && is_pccr && (pccr_idx_o == 4'(i));
    end
  end

endmodule

`default_nettype wire

// ==== hdl/csr_file_top.sv ====
// machine-mode csr file: access port, trap registers and performance counters
`timescale 1ns/1ps
`default_nettype none

module csr_file_top #(
  parameter int CNT_W = 32
) (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  // hart identity and boot vector
  input  wire logic [3:0]                     core_id_i,
  input  wire logic [5:0]                     cluster_id_i,
  input  wire logic [23:0]                    boot_addr_i,
  // csr access port
  input  wire logic                           csr_access_i,
  input  wire logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  csr_pkg::csr_op_e                    csr_op_i,
  input  wire logic [csr_pkg::XLEN-1:0]       csr_wdata_i,
  output logic      [csr_pkg::XLEN-1:0]       csr_rdata_o,
  // controller trap interface
  input  wire logic [csr_pkg::XLEN-1:0]       pc_if_i,
  input  wire logic [csr_pkg::XLEN-1:0]       pc_id_i,
  input  wire logic                           csr_save_if_i,
  input  wire logic                           csr_save_id_i,
  input  wire logic                           csr_save_cause_i,
  input  wire logic [csr_pkg::MCAUSE_W-1:0]   csr_cause_i,
  input  wire logic                           csr_restore_mret_i,
  output logic      [csr_pkg::XLEN-1:0]       epc_o,
  output logic      [23:0]                    mtvec_o,
  output logic                                m_irq_enable_o,
  // raw core events
  input  wire logic                           id_valid_i,
  input  wire logic                           is_compressed_i,
  input  wire logic                           is_decoding_i,
  input  wire logic                           imiss_i,
  input  wire logic                           pc_set_i,
  input  wire logic                           jump_i,
  input  wire logic                           branch_i,
  input  wire logic                           branch_taken_i,
  input  wire logic                           ld_stall_i,
  input  wire logic                           jr_stall_i,
  input  wire logic                           mem_load_i,
  input  wire logic                           mem_store_i
);

  import csr_pkg::*;

  // write side, from the access decoder
  logic [XLEN-1:0]       csr_wdata_int;
  logic                  mstatus_we;
  logic                  mepc_we;
  logic                  mcause_we;
  logic                  pcer_we;
  logic                  pcmr_we;
  logic [N_PERF_EVT-1:0] pccr_we;
  logic [3:0]            pccr_idx;

  // read side, back to the decoder
  logic [1:0]            mstatus_rd;
  logic [XLEN-1:0]       mepc_rd;
  logic [MCAUSE_W-1:0]   mcause_rd;
  logic [N_PERF_EVT-1:0] pcer_rd;
  logic [PCMR_W-1:0]     pcmr_rd;
  logic [XLEN-1:0]       pccr_rd;

  // counter side
  logic [N_PERF_EVT-1:0] cnt_inc;
  logic                  sat_en;

  // trap vector is the boot address, not writable
  assign mtvec_o = boot_addr_i;

  csr_access_ctrl u_access (
    .csr_access_i    (csr_access_i),
    .csr_addr_i      (csr_addr_i),
    .csr_op_i        (csr_op_i),
    .csr_wdata_i     (csr_wdata_i),
    .core_id_i       (core_id_i),
    .cluster_id_i    (cluster_id_i),
    .boot_addr_i     (boot_addr_i),
    .mstatus_rd_i    (mstatus_rd),
    .mepc_rd_i       (mepc_rd),
    .mcause_rd_i     (mcause_rd),
    .pcer_rd_i       (pcer_rd),
    .pcmr_rd_i       (pcmr_rd),
    .pccr_rd_i       (pccr_rd),
    .csr_rdata_o     (csr_rdata_o),
    .csr_wdata_int_o (csr_wdata_int),
    .mstatus_we_o    (mstatus_we),
    .mepc_we_o       (mepc_we),
    .mcause_we_o     (mcause_we),
    .pcer_we_o       (pcer_we),
    .pcmr_we_o       (pcmr_we),
    .pccr_we_o       (pccr_we),
    .pccr_idx_o      (pccr_idx)
  );

  csr_trap_regs u_trap (
    .clk                (clk),
    .rst_n              (rst_n),
    .csr_wdata_i        (csr_wdata_int),
    .mstatus_we_i       (mstatus_we),
    .mepc_we_i          (mepc_we),
    .mcause_we_i        (mcause_we),
    .csr_save_cause_i   (csr_save_cause_i),
    .csr_save_if_i      (csr_save_if_i),
    .csr_save_id_i      (csr_save_id_i),
    .csr_restore_mret_i (csr_restore_mret_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .csr_cause_i        (csr_cause_i),
    .mstatus_rd_o       (mstatus_rd),
    .mepc_rd_o          (mepc_rd),
    .mcause_rd_o        (mcause_rd),
    .epc_o              (epc_o),
    .m_irq_enable_o     (m_irq_enable_o)
  );

  perf_event_gen u_evt (
    .clk             (clk),
    .rst_n           (rst_n),
    .id_valid_i      (id_valid_i),
    .is_compressed_i (is_compressed_i),
    .is_decoding_i   (is_decoding_i),
    .imiss_i         (imiss_i),
    .pc_set_i        (pc_set_i),
    .jump_i          (jump_i),
    .branch_i        (branch_i),
    .branch_taken_i  (branch_taken_i),
    .ld_stall_i      (ld_stall_i),
    .jr_stall_i      (jr_stall_i),
    .mem_load_i      (mem_load_i),
    .mem_store_i     (mem_store_i),
    .csr_wdata_i     (csr_wdata_int),
    .pcer_we_i       (pcer_we),
    .pcmr_we_i       (pcmr_we),
    .pcer_rd_o       (pcer_rd),
    .pcmr_rd_o       (pcmr_rd),
    .cnt_inc_o       (cnt_inc),
    .sat_en_o        (sat_en)
  );

  perf_counter_bank #(
    .CNT_W (CNT_W)
  ) u_cnt (
    .clk         (clk),
    .rst_n       (rst_n),
    .cnt_inc_i   (cnt_inc),
    .sat_en_i    (sat_en),
    .pccr_we_i   (pccr_we),
    .pccr_idx_i  (pccr_idx),
    .csr_wdata_i (csr_wdata_int),
    .pccr_rd_o   (pccr_rd)
  );

endmodule

`default_nettype wire

// ==== dv/tb_csr_model.svh ====
// csr file reference model: register state, expected read data and error counting
`ifndef TB_CSR_MODEL_SVH
`define TB_CSR_MODEL_SVH

//////////////////////////////
// model state, one step per rising edge
//////////////////////////////
logic        m_mie;
logic        m_mpie;
logic [31:0] m_mepc;
logic [5:0]  m_mcause;
logic [10:0] m_pcer;
logic [1:0]  m_pcmr;
logic [31:0] m_cnt [11];
// registered increments and last cycle's id_valid
logic [10:0] m_inc;
logic        m_idv_q;
int          n_checks;
int          n_errors;

task automatic reset_model();
  m_mie    = 1'b0;
  m_mpie   = 1'b0;
  m_mepc   = '0;
  m_mcause = '0;
  m_pcer   = '0;
  // enabled and saturating after reset
  m_pcmr   = 2'b11;
  m_inc    = '0;
  m_idv_q  = 1'b0;
  for (int i = 0; i < 11; i++) begin
    m_cnt[i] = '0;
  end
endtask

// expected csr_rdata_o for an address, from the model state
function automatic logic [31:0] expected_rdata(input logic [11:0] addr);
  logic [31:0] r;
  r = '0;
  case (addr)
    12'h300: begin
      r[12:11] = 2'b11;
      r[7]     = m_mpie;
      r[3]     = m_mie;
    end
    12'h305: r = {boot_addr, 8'h00};
    12'h341: r = m_mepc;
    12'h342: begin
      // interrupt flag at the msb
      r[31]  = m_mcause[5];
      r[4:0] = m_mcause[4:0];
    end
    12'hF14: r = {21'b0, cluster_id, 1'b0, core_id};
    12'h7A0: r[10:0] = m_pcer;
    12'h7A1: r[1:0] = m_pcmr;
    default: begin
      if (addr >= 12'h780 && addr <= 12'h78A) begin
        r = m_cnt[addr[3:0]];
      end
    end
  endcase
  return r;
endfunction

// advance the model by one clock with the inputs of this cycle
task automatic update_model();
  logic [31:0] rd;
  logic [31:0] wv;
  logic        we;
  logic [10:0] evt;
  logic [10:0] inc_n;
  rd = expected_rdata(csr_addr);
  case (csr_op)
    CSR_OP_SET:   wv = csr_wdata | rd;
    CSR_OP_CLEAR: wv = rd & ~csr_wdata;
    default:      wv = csr_wdata;
  endcase
  we = csr_access && (csr_op != CSR_OP_NONE);
  // event conditions on this cycle's inputs
  evt[0]  = 1'b1;
  evt[1]  = id_valid & is_decoding;
  evt[2]  = ld_stall & m_idv_q;
  evt[3]  = jr_stall & m_idv_q;
  evt[4]  = imiss & ~pc_set;
  evt[5]  = mem_load;
  evt[6]  = mem_store;
  evt[7]  = jump & m_idv_q;
  evt[8]  = branch & m_idv_q;
  evt[9]  = branch & branch_taken & m_idv_q;
  evt[10] = id_valid & is_decoding & is_compressed;
  inc_n   = evt & m_pcer & {11{m_pcmr[0]}};
  // counters use last cycle's increments, a write wins
  for (int i = 0; i < 11; i++) begin
    if (we && csr_addr == 12'(12'h780 + i)) begin
      m_cnt[i] = wv;
    end else if (m_inc[i] && !(m_pcmr[1] && m_cnt[i] == 32'hFFFF_FFFF)) begin
      m_cnt[i] = m_cnt[i] + 32'd1;
    end
  end
  if (we && csr_addr == 12'h7A0) begin
    m_pcer = wv[10:0];
  end
  if (we && csr_addr == 12'h7A1) begin
    m_pcmr = wv[1:0];
  end
  m_inc   = inc_n;
  m_idv_q = id_valid;
  // trap save beats mret, both beat a csr write
  if (save_cause) begin
    m_mepc   = save_if ? pc_if : pc_id;
    m_mcause = cause;
    m_mpie   = m_mie;
    m_mie    = 1'b0;
  end else if (mret) begin
    m_mie  = m_mpie;
    m_mpie = 1'b1;
  end else if (we) begin
    case (csr_addr)
      12'h300: begin
        m_mie  = wv[3];
        m_mpie = wv[7];
      end
      12'h341: m_mepc = wv;
      12'h342: m_mcause = wv[5:0];
      default: ;
    endcase
  end
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
  n_checks++;
  assert (got === exp) else begin
    n_errors++;
    $display("Error: %s is %h, expected %h (addr %h, t=%0t)", name, got, exp, csr_addr, $time);
  end
endtask

`endif

// ==== dv/tb_csr_file.sv ====
// testbench for the machine-mode csr file: csr access, traps and performance counters
`timescale 1ns/1ps
`default_nettype none

module tb_csr_file;

  import csr_pkg::*;

  localparam int N_RAND_ACC  = 200;
  localparam int N_EVT_CYC   = 120;
  // directed accesses outside the random loops, with margin
  localparam int N_FIXED     = 150;
  localparam int WATCHDOG_NS = (2 * N_RAND_ACC + N_EVT_CYC + N_FIXED) * 20 * 4;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [3:0]  core_id;
  logic [5:0]  cluster_id;
  logic [23:0] boot_addr;
  logic        csr_access;
  logic [11:0] csr_addr;
  csr_op_e     csr_op;
  logic [31:0] csr_wdata;
  logic [31:0] csr_rdata;
  logic [31:0] pc_if;
  logic [31:0] pc_id;
  logic        save_if;
  logic        save_id;
  logic        save_cause;
  logic [5:0]  cause;
  logic        mret;
  logic [31:0] epc;
  logic [23:0] mtvec;
  logic        m_irq_en;
  // raw core events
  logic        id_valid;
  logic        is_compressed;
  logic        is_decoding;
  logic        imiss;
  logic        pc_set;
  logic        jump;
  logic        branch;
  logic        branch_taken;
  logic        ld_stall;
  logic        jr_stall;
  logic        mem_load;
  logic        mem_store;

  `include "tb_csr_model.svh"

  csr_file_top dut0 (
    .clk (clk), .rst_n (rst_n),
    .core_id_i (core_id), .cluster_id_i (cluster_id), .boot_addr_i (boot_addr),
    .csr_access_i (csr_access), .csr_addr_i (csr_addr), .csr_op_i (csr_op),
    .csr_wdata_i (csr_wdata), .csr_rdata_o (csr_rdata),
    .pc_if_i (pc_if), .pc_id_i (pc_id), .csr_save_if_i (save_if),
    .csr_save_id_i (save_id), .csr_save_cause_i (save_cause), .csr_cause_i (cause),
    .csr_restore_mret_i (mret), .epc_o (epc), .mtvec_o (mtvec), .m_irq_enable_o (m_irq_en),
    .id_valid_i (id_valid), .is_compressed_i (is_compressed), .is_decoding_i (is_decoding),
    .imiss_i (imiss), .pc_set_i (pc_set), .jump_i (jump), .branch_i (branch),
    .branch_taken_i (branch_taken), .ld_stall_i (ld_stall), .jr_stall_i (jr_stall),
    .mem_load_i (mem_load), .mem_store_i (mem_store)
  );

  always #10 clk = ~clk;

  //////////////////////////////
  // checker, just before each rising edge
  //////////////////////////////
  always begin
    @(negedge clk);
    #9;
    if (!rst_n) begin
      reset_model();
    end else begin
      check_value("csr_rdata_o", csr_rdata, expected_rdata(csr_addr));
      check_value("epc_o", epc, m_mepc);
      check_value("m_irq_enable_o", {31'b0, m_irq_en}, {31'b0, m_mie});
      // trap vector follows the boot address
      check_value("mtvec_o", {8'b0, mtvec}, {8'b0, boot_addr});
      update_model();
    end
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, stimulus did not complete", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // one access cycle, trap controls released
  task automatic csr_cycle(input logic acc, input csr_op_e op, input logic [11:0] addr,
                           input logic [31:0] wdata);
    @(negedge clk);
    csr_access = acc;
    csr_op     = op;
    csr_addr   = addr;
    csr_wdata  = wdata;
    save_cause = 1'b0;
    save_if    = 1'b0;
    save_id    = 1'b0;
    mret       = 1'b0;
  endtask

  task automatic read_csr(input logic [11:0] addr);
    csr_cycle(1'b0, CSR_OP_NONE, addr, $urandom());
  endtask

  // read, then compare against a fixed value at the sample point
  task automatic read_and_expect(input logic [11:0] addr, input logic [31:0] exp);
    read_csr(addr);
    #9;
    check_value("csr_rdata_o", csr_rdata, exp);
  endtask

  // sel 0 takes neither stage flag, 1 the if pc, 2 the id pc
  task automatic trap_save_with_write(input int sel);
    csr_cycle(1'b1, CSR_OP_WRITE, ADDR_MEPC, $urandom());
    save_cause = 1'b1;
    save_if    = (sel == 1);
    save_id    = (sel == 2);
    pc_if      = $urandom();
    pc_id      = $urandom();
    cause      = 6'($urandom_range(0, 63));
  endtask

  task automatic mret_with_write();
    csr_cycle(1'b1, CSR_OP_WRITE, ADDR_MSTATUS, $urandom());
    mret = 1'b1;
  endtask

  task automatic set_events(input logic rnd);
    id_valid      = rnd & 1'($urandom_range(0, 1));
    is_compressed = rnd & 1'($urandom_range(0, 1));
    is_decoding   = rnd & 1'($urandom_range(0, 1));
    imiss         = rnd & 1'($urandom_range(0, 1));
    pc_set        = rnd & 1'($urandom_range(0, 1));
    jump          = rnd & 1'($urandom_range(0, 1));
    branch        = rnd & 1'($urandom_range(0, 1));
    branch_taken  = rnd & 1'($urandom_range(0, 1));
    ld_stall      = rnd & 1'($urandom_range(0, 1));
    jr_stall      = rnd & 1'($urandom_range(0, 1));
    mem_load      = rnd & 1'($urandom_range(0, 1));
    mem_store     = rnd & 1'($urandom_range(0, 1));
  endtask

  // counter 0 from 0xFFFFFFFD through exactly four cycle events
  task automatic count_four_cycles(input logic sat, input logic [31:0] exp);
    csr_cycle(1'b1, CSR_OP_WRITE, ADDR_PCMR, {30'b0, sat, 1'b0});
    csr_cycle(1'b1, CSR_OP_WRITE, ADDR_PCER, 32'h1);
    csr_cycle(1'b1, CSR_OP_WRITE, ADDR_PCCR_BASE, 32'hFFFF_FFFD);
    csr_cycle(1'b1, CSR_OP_WRITE, ADDR_PCMR, {30'b0, sat, 1'b1});
    repeat (3) read_csr(ADDR_PCCR_BASE);
    csr_cycle(1'b1, CSR_OP_WRITE, ADDR_PCMR, {30'b0, sat, 1'b0});
    // pipeline drains in two cycles
    repeat (2) read_csr(ADDR_PCCR_BASE);
    read_and_expect(ADDR_PCCR_BASE, exp);
  endtask

  logic [11:0] rnd_addr;

  initial begin
    void'($urandom(55));
    rst_n      = 1'b0;
    core_id    = 4'($urandom());
    cluster_id = 6'($urandom());
    boot_addr  = 24'($urandom());
    csr_access = 1'b0;
    csr_addr   = '0;
    csr_op     = CSR_OP_NONE;
    csr_wdata  = '0;
    pc_if      = '0;
    pc_id      = '0;
    save_if    = 1'b0;
    save_id    = 1'b0;
    save_cause = 1'b0;
    cause      = '0;
    mret       = 1'b0;
    set_events(1'b0);
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // reset values and read-only registers
    read_and_expect(ADDR_MSTATUS, 32'h0000_1800);
    read_and_expect(ADDR_MEPC, 32'h0);
    read_and_expect(ADDR_MCAUSE, 32'h0);
    read_and_expect(ADDR_PCER, 32'h0);
    read_and_expect(ADDR_PCMR, 32'h3);
    read_and_expect(ADDR_MTVEC, {boot_addr, 8'h00});
    read_and_expect(ADDR_MHARTID, {21'b0, cluster_id, 1'b0, core_id});
    read_and_expect(12'h001, 32'h0);
    read_and_expect(12'h78B, 32'h0);
    read_and_expect(12'h7A2, 32'h0);
    read_and_expect(12'hFFF, 32'h0);

    // random access to the trap registers, some with access low
    repeat (N_RAND_ACC) begin
      case ($urandom_range(0, 2))
        0:       rnd_addr = ADDR_MSTATUS;
        1:       rnd_addr = ADDR_MEPC;
        default: rnd_addr = ADDR_MCAUSE;
      endcase
      csr_cycle(($urandom_range(0, 3) != 0), csr_op_e'($urandom_range(0, 3)), rnd_addr,
                $urandom());
      read_csr(rnd_addr);
    end

    // trap save for each pc source, then mret
    for (int sel = 0; sel < 3; sel++) begin
      // mie low with mpie high on the first pass, mie high on the others
      csr_cycle(1'b1, CSR_OP_WRITE, ADDR_MSTATUS, (sel == 0) ? 32'h80 : 32'h08);
      trap_save_with_write(sel);
      read_csr(ADDR_MEPC);
      read_csr(ADDR_MCAUSE);
      read_csr(ADDR_MSTATUS);
    end
    repeat (4) begin
      csr_cycle(1'b1, CSR_OP_WRITE, ADDR_MSTATUS, $urandom());
      mret_with_write();
      read_csr(ADDR_MSTATUS);
    end

    // counters: preload while disabled, run random events, stop
    csr_cycle(1'b1, CSR_OP_WRITE, ADDR_PCMR, 32'h2);
    csr_cycle(1'b1, CSR_OP_WRITE, ADDR_PCER, 32'h7FF);
    for (int i = 0; i < N_PERF_EVT; i++) begin
      csr_cycle(1'b1, CSR_OP_WRITE, ADDR_PCCR_BASE + 12'(i), $urandom());
    end
    csr_cycle(1'b1, CSR_OP_WRITE, ADDR_PCMR, 32'h3);
    repeat (N_EVT_CYC) begin
      read_csr(ADDR_PCCR_BASE + 12'($urandom_range(0, N_PERF_EVT - 1)));
      set_events(1'b1);
    end
    csr_cycle(1'b1, CSR_OP_WRITE, ADDR_PCMR, 32'h2);
    set_events(1'b0);
    repeat (2) read_csr(ADDR_PCER);
    for (int i = 0; i < N_PERF_EVT; i++) begin
      read_csr(ADDR_PCCR_BASE + 12'(i));
    end

    // saturation holds at all ones, otherwise wrap
    count_four_cycles(1'b1, 32'hFFFF_FFFF);
    count_four_cycles(1'b0, 32'h0000_0001);

    read_csr(12'h000);
    @(posedge clk);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+dv
hdl/csr_pkg.sv
hdl/perf_counter_bank.sv
hdl/perf_event_gen.sv
hdl/csr_trap_regs.sv
hdl/csr_access_ctrl.sv
hdl/csr_file_top.sv
dv/tb_csr_file.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the csr file testbench with Verilator, run it, and grade the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f all.f --top-module tb_csr_file -o sim_csr > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "compile failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/sim_csr > "$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see $SIM_LOG"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$SIM_LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL, see $SIM_LOG"
  exit 1
fi
